//--- hdl/eth_mii_pkg.sv
// Shared frame constants, FSM state types and the CRC-32 nibble update for the MII MAC.
`default_nettype none

package eth_mii_pkg;

    // nibbles of 0x5 sent ahead of the SFD nibble.
    localparam int preamble_nibbles = 15;

    // minimum frame length in bytes, FCS included.
    localparam int min_frame_len = 64;
    localparam int fcs_len = 4;
    localparam int min_payload_len = min_frame_len - fcs_len;

    // reflected CRC register value left over a good frame plus its FCS.
    localparam logic [31:0] crc_residue = 32'hdebb20e3;

    // statistics counter width.
    localparam int stat_w = 32;

    typedef enum logic [2:0] {
        tx_idle,
        tx_preamble,
        tx_data,
        tx_pad,
        tx_fcs,
        tx_ifg
    } tx_state_t;

    typedef enum logic [1:0] {
        rx_idle,
        rx_preamble,
        rx_data,
        rx_drop
    } rx_state_t;

    // one nibble of the reflected 0xEDB88320 CRC, lsb first.
    function automatic logic [31:0] crc32_nibble(input logic [31:0] crc, input logic [3:0] nib);
        logic [31:0] c;
        c = crc;
        for (int i = 0; i < 4; i++) begin
            if (c[0] ^ nib[i]) begin
                c = (c >> 1) ^ 32'hedb88320;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage

`default_nettype wire

//--- hdl/eth_mac_mii_tx.sv
// MII transmit path that frames a byte stream with preamble, zero pad, FCS and inter-frame gap.
`timescale 1ns/1ps
`default_nettype none

module eth_mac_mii_tx (
    input  wire logic       clk,
    input  wire logic       reset,

    // byte stream from the user.
    input  wire logic [7:0] tx_tdata,
    input  wire logic       tx_tvalid,
    input  wire logic       tx_tlast,
    output wire logic       tx_tready,

    // MII transmit side.
    output logic [3:0]      mii_txd,
    output logic            mii_tx_en,
    output logic            mii_tx_er,

    // status pulses.
    output logic            tx_start_packet,
    output logic            tx_error_underflow,

    input  wire logic [7:0] cfg_ifg,
    input  wire logic       cfg_tx_enable
);
    import eth_mii_pkg::*;

    tx_state_t   state;
    logic [3:0]  nib_cnt;
    logic        phase;
    logic [6:0]  byte_cnt;
    logic [7:0]  byte_q;
    logic        last_q;
    logic [31:0] crc;
    logic [8:0]  ifg_cnt;
    logic        drop_rest;
    logic        need_byte;
    logic [3:0]  hi_nib;

    // a new byte is due while the SFD or the high nibble of a non-final byte is on the wire.
    assign need_byte = (state == tx_preamble && nib_cnt == 4'(preamble_nibbles)) ||
                       (state == tx_data && phase && !last_q);

    // after an underflow the rest of the frame is accepted and thrown away.
    assign tx_tready = need_byte || drop_rest;

    assign hi_nib = (state == tx_data) ? byte_q[7:4] : 4'h0;

    always_ff @(posedge clk) begin
        tx_start_packet <= 1'b0;
        tx_error_underflow <= 1'b0;

        if (drop_rest && tx_tvalid && tx_tlast) begin
            drop_rest <= 1'b0;
        end

        if (need_byte) begin
            if (tx_tvalid) begin
                state <= tx_data;
                phase <= 1'b0;
                byte_q <= tx_tdata;
                last_q <= tx_tlast;
                mii_txd <= tx_tdata[3:0];
                crc <= crc32_nibble(crc, tx_tdata[3:0]);
            end else begin
                // source ran dry, so abort with two error nibbles and no FCS.
                tx_error_underflow <= 1'b1;
                drop_rest <= 1'b1;
                state <= tx_fcs;
                nib_cnt <= 4'(2 * fcs_len - 2);
                mii_txd <= 4'h0;
                mii_tx_er <= 1'b1;
            end
        end else begin
            case (state)
                tx_idle: begin
                    if (cfg_tx_enable && tx_tvalid && !drop_rest) begin
                        state <= tx_preamble;
                        nib_cnt <= 4'd0;
                        mii_tx_en <= 1'b1;
                        mii_txd <= 4'h5;
                        crc <= '1;
                        byte_cnt <= '0;
                    end
                end
                tx_preamble: begin
                    nib_cnt <= nib_cnt + 4'd1;
                    if (nib_cnt == 4'(preamble_nibbles - 1)) begin
                        mii_txd <= 4'hd;
                        tx_start_packet <= 1'b1;
                    end else begin
                        mii_txd <= 4'h5;
                    end
                end
                tx_data, tx_pad: begin
                    if (!phase) begin
                        phase <= 1'b1;
                        mii_txd <= hi_nib;
                        crc <= crc32_nibble(crc, hi_nib);
                        if (byte_cnt < 7'(min_payload_len)) begin
                            byte_cnt <= byte_cnt + 7'd1;
                        end
                    end else if (byte_cnt < 7'(min_payload_len)) begin
                        // frame still short of the minimum, keep padding with zeros.
                        state <= tx_pad;
                        phase <= 1'b0;
                        mii_txd <= 4'h0;
                        crc <= crc32_nibble(crc, 4'h0);
                    end else begin
                        state <= tx_fcs;
                        nib_cnt <= 4'd0;
                        mii_txd <= ~crc[3:0];
                    end
                end
                tx_fcs: begin
                    if (nib_cnt == 4'(2 * fcs_len - 1)) begin
                        state <= tx_ifg;
                        mii_tx_en <= 1'b0;
                        mii_tx_er <= 1'b0;
                        mii_txd <= 4'h0;
                        ifg_cnt <= {cfg_ifg, 1'b0};
                    end else begin
                        // the CRC shifts down so the next FCS nibble is always at the bottom.
                        nib_cnt <= nib_cnt + 4'd1;
                        mii_txd <= mii_tx_er ? 4'h0 : ~crc[7:4];
                        crc <= crc >> 4;
                    end
                end
                tx_ifg: begin
                    ifg_cnt <= ifg_cnt - 9'd1;
                    if (ifg_cnt <= 9'd1) begin
                        state <= tx_idle;
                    end
                end
                default: begin
                    state <= tx_idle;
                end
            endcase
        end

        if (reset) begin
            state <= tx_idle;
            nib_cnt <= 4'd0;
            phase <= 1'b0;
            byte_cnt <= '0;
            ifg_cnt <= '0;
            drop_rest <= 1'b0;
            mii_txd <= 4'h0;
            mii_tx_en <= 1'b0;
            mii_tx_er <= 1'b0;
            tx_start_packet <= 1'b0;
            tx_error_underflow <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_mac_mii_rx.sv
// MII receive path that finds the SFD, builds bytes, strips the FCS and judges each frame.
`timescale 1ns/1ps
`default_nettype none

module eth_mac_mii_rx (
    input  wire logic       clk,
    input  wire logic       reset,

    // MII receive side.
    input  wire logic [3:0] mii_rxd,
    input  wire logic       mii_rx_dv,
    input  wire logic       mii_rx_er,

    // byte stream to the user, no back-pressure.
    output logic [7:0]      rx_tdata,
    output logic            rx_tvalid,
    output logic            rx_tlast,
    output logic            rx_tuser,

    // status pulses.
    output logic            rx_start_packet,
    output logic            rx_frame_good,
    output logic            rx_error_bad_frame,
    output logic            rx_error_bad_fcs,

    input  wire logic       cfg_rx_enable
);
    import eth_mii_pkg::*;

    rx_state_t   state;
    logic        phase;
    logic [3:0]  nib_lo;
    logic [6:0]  byte_cnt;
    logic [31:0] crc;
    logic        er_seen;
    logic        bad_frame;
    logic        bad_fcs;

    // holds the newest bytes so the trailing FCS never reaches the stream.
    logic [7:0]  win [fcs_len + 1];

    // runt, odd nibble count or a coded error.
    assign bad_frame = (byte_cnt < 7'(min_frame_len)) || phase || er_seen;
    assign bad_fcs = (crc != crc_residue);

    always_ff @(posedge clk) begin
        rx_tvalid <= 1'b0;
        rx_tlast <= 1'b0;
        rx_tuser <= 1'b0;
        rx_start_packet <= 1'b0;
        rx_frame_good <= 1'b0;
        rx_error_bad_frame <= 1'b0;
        rx_error_bad_fcs <= 1'b0;

        case (state)
            rx_idle, rx_preamble: begin
                crc <= '1;
                phase <= 1'b0;
                byte_cnt <= '0;
                er_seen <= 1'b0;
                if (!mii_rx_dv) begin
                    state <= rx_idle;
                end else if (state == rx_idle && !cfg_rx_enable) begin
                    state <= rx_drop;
                end else if (mii_rxd == 4'h5) begin
                    state <= rx_preamble;
                end else if (mii_rxd == 4'hd) begin
                    state <= rx_data;
                    rx_start_packet <= 1'b1;
                    er_seen <= mii_rx_er;
                end else begin
                    state <= rx_drop;
                end
            end
            rx_data: begin
                if (mii_rx_dv) begin
                    crc <= crc32_nibble(crc, mii_rxd);
                    phase <= !phase;
                    er_seen <= er_seen || mii_rx_er;
                    if (!phase) begin
                        nib_lo <= mii_rxd;
                    end else begin
                        win[0] <= {mii_rxd, nib_lo};
                        for (int i = 1; i <= fcs_len; i++) begin
                            win[i] <= win[i - 1];
                        end
                        if (byte_cnt < 7'(min_frame_len)) begin
                            byte_cnt <= byte_cnt + 7'd1;
                        end
                        // window full, so the oldest byte is known not to be FCS.
                        if (byte_cnt >= 7'(fcs_len + 1)) begin
                            rx_tvalid <= 1'b1;
                            rx_tdata <= win[fcs_len];
                        end
                    end
                end else begin
                    state <= rx_idle;
                    if (byte_cnt > 7'(fcs_len + 1)) begin
                        rx_tvalid <= 1'b1;
                        rx_tdata <= win[fcs_len];
                        rx_tlast <= 1'b1;
                        rx_tuser <= bad_frame || bad_fcs;
                    end
                    rx_error_bad_frame <= bad_frame;
                    rx_error_bad_fcs <= !bad_frame && bad_fcs;
                    rx_frame_good <= !bad_frame && !bad_fcs;
                end
            end
            rx_drop: begin
                // false carrier, wait for the line to go quiet.
                if (!mii_rx_dv) begin
                    state <= rx_idle;
                end
            end
            default: begin
                state <= rx_idle;
            end
        endcase

        if (reset) begin
            state <= rx_idle;
            phase <= 1'b0;
            byte_cnt <= '0;
            er_seen <= 1'b0;
            rx_tvalid <= 1'b0;
            rx_tlast <= 1'b0;
            rx_tuser <= 1'b0;
            rx_start_packet <= 1'b0;
            rx_frame_good <= 1'b0;
            rx_error_bad_frame <= 1'b0;
            rx_error_bad_fcs <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_mac_stats.sv
// Saturating event counters fed by the status pulses of both MAC paths.
`timescale 1ns/1ps
`default_nettype none

module eth_mac_stats (
    input  wire logic                         clk,
    input  wire logic                         reset,

    input  wire logic                         tx_start_packet,
    input  wire logic                         tx_error_underflow,
    input  wire logic                         rx_frame_good,
    input  wire logic                         rx_error_bad_frame,
    input  wire logic                         rx_error_bad_fcs,

    output wire logic [eth_mii_pkg::stat_w-1:0] stat_tx_frames,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_tx_underflow,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_rx_good,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_rx_bad_frame,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_rx_bad_fcs,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_rx_frames
);
    import eth_mii_pkg::*;

    // one increment strobe per counter.
    logic [5:0]        inc;
    logic [stat_w-1:0] count [6];

    // every receive verdict lands in the combined frame count.
    assign inc = {
        rx_frame_good | rx_error_bad_frame | rx_error_bad_fcs,
        rx_error_bad_fcs,
        rx_error_bad_frame,
        rx_frame_good,
        tx_error_underflow,
        tx_start_packet
    };

    always_ff @(posedge clk) begin
        for (int i = 0; i < 6; i++) begin
            if (reset) begin
                count[i] <= '0;
            end else if (inc[i] && count[i] != '1) begin
                count[i] <= count[i] + stat_w'(1);
            end
        end
    end

    assign stat_tx_frames = count[0];
    assign stat_tx_underflow = count[1];
    assign stat_rx_good = count[2];
    assign stat_rx_bad_frame = count[3];
    assign stat_rx_bad_fcs = count[4];
    assign stat_rx_frames = count[5];

endmodule

`default_nettype wire

//--- hdl/eth_mac_mii.sv
// 10/100 Ethernet MAC top level joining the MII transmit and receive paths with statistics.
`timescale 1ns/1ps
`default_nettype none

module eth_mac_mii (
    input  wire logic                           clk,
    input  wire logic                           reset,

    // transmit stream.
    input  wire logic [7:0]                     tx_tdata,
    input  wire logic                           tx_tvalid,
    input  wire logic                           tx_tlast,
    output wire logic                           tx_tready,

    // receive stream.
    output wire logic [7:0]                     rx_tdata,
    output wire logic                           rx_tvalid,
    output wire logic                           rx_tlast,
    output wire logic                           rx_tuser,

    // MII.
    input  wire logic [3:0]                     mii_rxd,
    input  wire logic                           mii_rx_dv,
    input  wire logic                           mii_rx_er,
    output wire logic [3:0]                     mii_txd,
    output wire logic                           mii_tx_en,
    output wire logic                           mii_tx_er,

    // status pulses.
    output wire logic                           tx_start_packet,
    output wire logic                           tx_error_underflow,
    output wire logic                           rx_start_packet,
    output wire logic                           rx_frame_good,
    output wire logic                           rx_error_bad_frame,
    output wire logic                           rx_error_bad_fcs,

    // counters.
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_tx_frames,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_tx_underflow,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_rx_good,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_rx_bad_frame,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_rx_bad_fcs,
    output wire logic [eth_mii_pkg::stat_w-1:0] stat_rx_frames,

    input  wire logic [7:0]                     cfg_ifg,
    input  wire logic                           cfg_tx_enable,
    input  wire logic                           cfg_rx_enable
);

    // port names line up across the hierarchy.
    eth_mac_mii_tx tx_inst (.*);

    eth_mac_mii_rx rx_inst (.*);

    // status pulses are shared with the ports above.
    eth_mac_stats stats_inst (.*);

endmodule

`default_nettype wire

//--- verification/eth_mac_mii_tb_tasks.svh
// Directed test tasks, frame builders, reference CRC and compare tasks for the MII MAC testbench.

    logic [7:0] frame_bytes [$];
    logic [3:0] exp_nibbles [$];
    logic [7:0] loop_bytes [$];
    logic [3:0] loop_nibbles [$];

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string msg);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s, got %h, expected %h",
                                      $time, msg, got, exp));
        end
    endtask

    task automatic check_nibble(input logic [3:0] got, input logic [3:0] exp, input string msg);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s, got %h, expected %h",
                                      $time, msg, got, exp));
        end
    endtask

    task automatic check_count(input logic [stat_w-1:0] got, input logic [stat_w-1:0] exp,
                               input string msg);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s, got %0d, expected %0d",
                                      $time, msg, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string msg);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s, got %b, expected %b",
                                      $time, msg, got, exp));
        end
    endtask

    // bitwise CRC-32 over frame_bytes, lsb first, returned already complemented.
    function automatic logic [31:0] reference_fcs();
        logic [31:0] c;
        c = 32'hffffffff;
        foreach (frame_bytes[i]) begin
            for (int b = 0; b < 8; b++) begin
                if (c[0] ^ frame_bytes[i][b]) begin
                    c = (c >> 1) ^ 32'hedb88320;
                end else begin
                    c = c >> 1;
                end
            end
        end
        return ~c;
    endfunction

    task automatic make_payload(input int len);
        int r;
        frame_bytes.delete();
        for (int i = 0; i < len; i++) begin
            r = $random(seed);
            frame_bytes.push_back(r[7:0]);
        end
    endtask

    task automatic pad_frame();
        while (frame_bytes.size() < min_payload_len) begin
            frame_bytes.push_back(8'h00);
        end
    endtask

    // appends preamble, SFD, data low nibble first and FCS to exp_nibbles.
    task automatic build_wire_image();
        logic [31:0] fcs;
        fcs = reference_fcs();
        repeat (preamble_nibbles) begin
            exp_nibbles.push_back(4'h5);
        end
        exp_nibbles.push_back(4'hd);
        foreach (frame_bytes[i]) begin
            exp_nibbles.push_back(frame_bytes[i][3:0]);
            exp_nibbles.push_back(frame_bytes[i][7:4]);
        end
        for (int i = 0; i < 2 * fcs_len; i++) begin
            exp_nibbles.push_back(fcs[4*i +: 4]);
        end
    endtask

    // a byte moves at the rising edge after a falling edge that sees tx_tready high.
    // hole is the byte index whose beat is withheld once, to force an underflow.
    task automatic send_tx_frame(input int len, input int hole, output int readies);
        int   idx;
        logic took;
        logic resume;
        idx = 0;
        took = 1'b0;
        resume = 1'b0;
        readies = 0;
        tx_tdata = frame_bytes[0];
        tx_tlast = (len == 1);
        tx_tvalid = 1'b1;
        while (idx < len) begin
            @(negedge clk);
            if (took) begin
                idx++;
                tx_tvalid = (idx < len) && (idx != hole);
                if (idx < len) begin
                    tx_tdata = frame_bytes[idx];
                    tx_tlast = (idx == len - 1);
                end else begin
                    tx_tlast = 1'b0;
                end
            end
            if (resume) begin
                tx_tvalid = 1'b1;
                resume = 1'b0;
            end
            took = tx_tready && tx_tvalid;
            if (tx_tready) begin
                readies++;
                resume = !tx_tvalid && (idx < len);
            end
        end
    endtask

    task automatic wait_tx_frames(input int count);
        while (tx_frames_seen < count) begin
            @(negedge clk);
        end
    endtask

    task automatic check_tx_capture(input string what);
        check_count(tx_nibbles.size(), exp_nibbles.size(), {what, " nibble count"});
        foreach (exp_nibbles[i]) begin
            check_nibble(tx_nibbles[i], exp_nibbles[i], $sformatf("%s nibble %0d", what, i));
        end
    endtask

    function automatic int rx_verdicts();
        return rx_good_pulses + rx_bad_frame_pulses + rx_bad_fcs_pulses;
    endfunction

    // plays exp_nibbles into the receive side and waits for the frame verdict.
    task automatic drive_rx_frame(input int er_at);
        int verdicts;
        verdicts = rx_verdicts();
        rx_bytes.delete();
        rx_last_count = 0;
        foreach (exp_nibbles[i]) begin
            @(negedge clk);
            mii_rx_dv = 1'b1;
            mii_rxd = exp_nibbles[i];
            mii_rx_er = (i == er_at);
        end
        @(negedge clk);
        mii_rx_dv = 1'b0;
        mii_rxd = 4'h0;
        mii_rx_er = 1'b0;
        while (rx_verdicts() == verdicts) begin
            @(negedge clk);
        end
    endtask

    task automatic check_rx_stream(input int count, input logic user_exp);
        check_count(rx_bytes.size(), count, "received byte count");
        for (int i = 0; i < count; i++) begin
            check_byte(rx_bytes[i], frame_bytes[i], $sformatf("received byte %0d", i));
        end
        check_count(rx_last_count, 1, "rx_tlast beats");
        check_count(rx_last_index, count - 1, "rx_tlast position");
        check_flag(rx_last_user, user_exp, "rx_tuser with rx_tlast");
    endtask

    task automatic check_reset_state();
        check_flag(mii_tx_en, 1'b0, "mii_tx_en after reset");
        check_flag(mii_tx_er, 1'b0, "mii_tx_er after reset");
        check_flag(tx_tready, 1'b0, "tx_tready after reset");
        check_flag(rx_tvalid, 1'b0, "rx_tvalid after reset");
        check_count(stat_tx_frames, 0, "stat_tx_frames after reset");
        check_count(stat_rx_frames, 0, "stat_rx_frames after reset");
    endtask

    task automatic test_padded_tx();
        int                readies;
        int                frames;
        int                starts;
        logic [stat_w-1:0] tx_before;
        frames = tx_frames_seen;
        starts = tx_start_pulses;
        tx_before = stat_tx_frames;
        tx_nibbles.delete();
        exp_nibbles.delete();
        make_payload(20);
        send_tx_frame(20, -1, readies);
        wait_tx_frames(frames + 1);
        pad_frame();
        build_wire_image();
        check_tx_capture("padded frame");
        check_count(readies, 20, "tx_tready beats of padded frame");
        @(negedge clk);
        check_count(tx_start_pulses - starts, 1, "tx_start_packet pulses");
        check_count(stat_tx_frames, tx_before + 1, "stat_tx_frames");
        // kept for the loopback test.
        loop_bytes = frame_bytes;
        loop_nibbles = tx_nibbles;
    endtask

    task automatic test_back_to_back_tx();
        int readies_a;
        int readies_b;
        int frames;
        cfg_ifg = 8'd12;
        frames = tx_frames_seen;
        tx_nibbles.delete();
        exp_nibbles.delete();
        make_payload(80);
        build_wire_image();
        send_tx_frame(80, -1, readies_a);
        make_payload(80);
        build_wire_image();
        send_tx_frame(80, -1, readies_b);
        wait_tx_frames(frames + 2);
        check_tx_capture("back-to-back frames");
        check_count(readies_a, 80, "tx_tready beats of first frame");
        check_count(readies_b, 80, "tx_tready beats of second frame");
        check_flag(tx_gap >= 24, 1'b1, $sformatf("inter-frame gap of %0d cycles", tx_gap));
    endtask

    task automatic test_good_rx();
        int                starts;
        logic [stat_w-1:0] good_before;
        starts = rx_start_pulses;
        good_before = stat_rx_good;
        exp_nibbles.delete();
        make_payload(66);
        build_wire_image();
        drive_rx_frame(-1);
        check_rx_stream(66, 1'b0);
        check_count(rx_start_pulses - starts, 1, "rx_start_packet pulses");
        @(negedge clk);
        check_count(stat_rx_good, good_before + 1, "stat_rx_good");
    endtask

    task automatic test_bad_rx();
        int                fcs_pulses;
        int                frame_pulses;
        int                last;
        logic [stat_w-1:0] fcs_before;
        logic [stat_w-1:0] frame_before;
        logic [stat_w-1:0] total_before;
        fcs_pulses = rx_bad_fcs_pulses;
        frame_pulses = rx_bad_frame_pulses;
        fcs_before = stat_rx_bad_fcs;
        frame_before = stat_rx_bad_frame;
        total_before = stat_rx_frames;

        // one FCS bit flipped.
        exp_nibbles.delete();
        make_payload(66);
        build_wire_image();
        last = exp_nibbles.size() - 1;
        exp_nibbles[last] = exp_nibbles[last] ^ 4'h8;
        drive_rx_frame(-1);
        check_rx_stream(66, 1'b1);
        check_count(rx_bad_fcs_pulses - fcs_pulses, 1, "rx_error_bad_fcs pulses");

        // runt of 40 bytes with a valid FCS.
        exp_nibbles.delete();
        make_payload(36);
        build_wire_image();
        drive_rx_frame(-1);
        check_rx_stream(36, 1'b1);
        check_count(rx_bad_frame_pulses - frame_pulses, 1, "rx_error_bad_frame pulses of runt");

        // coded error inside the data.
        exp_nibbles.delete();
        make_payload(66);
        build_wire_image();
        drive_rx_frame(40);
        check_rx_stream(66, 1'b1);
        check_count(rx_bad_frame_pulses - frame_pulses, 2, "rx_error_bad_frame pulses");

        @(negedge clk);
        check_count(stat_rx_bad_fcs, fcs_before + 1, "stat_rx_bad_fcs");
        check_count(stat_rx_bad_frame, frame_before + 2, "stat_rx_bad_frame");
        check_count(stat_rx_frames, total_before + 3, "stat_rx_frames");
        check_count(stat_rx_frames, stat_rx_good + stat_rx_bad_frame + stat_rx_bad_fcs,
                    "stat_rx_frames against the sum of receive counters");
    endtask

    task automatic test_tx_underflow();
        int                readies;
        int                frames;
        int                under_before;
        logic [stat_w-1:0] stat_before;
        frames = tx_frames_seen;
        under_before = underflow_pulses;
        stat_before = stat_tx_underflow;
        tx_er_nibbles = 0;
        make_payload(30);
        send_tx_frame(30, 10, readies);
        wait_tx_frames(frames + 1);
        @(negedge clk);
        check_count(underflow_pulses - under_before, 1, "tx_error_underflow pulses");
        check_count(tx_er_nibbles, 2, "nibbles with mii_tx_er high");
        check_count(stat_tx_underflow, stat_before + 1, "stat_tx_underflow");
    endtask

    task automatic test_loopback();
        logic [stat_w-1:0] good_before;
        good_before = stat_rx_good;
        frame_bytes = loop_bytes;
        exp_nibbles = loop_nibbles;
        drive_rx_frame(-1);
        check_rx_stream(min_payload_len, 1'b0);
        @(negedge clk);
        check_count(stat_rx_good, good_before + 1, "stat_rx_good after loopback");
    endtask

//--- verification/eth_mac_mii_tb.sv
// Testbench for the MII MAC; runs directed transmit, receive, underflow and loopback tests.
`timescale 1ns/1ps
`default_nettype none

module eth_mac_mii_tb;
    import eth_mii_pkg::*;

    // nibbles of all frames in the run, then transmit gaps and idle time between tests.
    localparam int frame_nibbles = 144 + 2 * 184 + 156 + (156 + 96 + 156) + 38 + 144;
    localparam int gap_cycles = 4 * 25 + 6 * 16 + 5;
    localparam int timeout_cycles = 2 * (frame_nibbles + gap_cycles);

    logic                clk;
    logic                reset;
    logic [7:0]          tx_tdata;
    logic                tx_tvalid;
    logic                tx_tlast;
    logic                tx_tready;
    logic [7:0]          rx_tdata;
    logic                rx_tvalid;
    logic                rx_tlast;
    logic                rx_tuser;
    logic [3:0]          mii_rxd;
    logic                mii_rx_dv;
    logic                mii_rx_er;
    logic [3:0]          mii_txd;
    logic                mii_tx_en;
    logic                mii_tx_er;
    logic                tx_start_packet;
    logic                tx_error_underflow;
    logic                rx_start_packet;
    logic                rx_frame_good;
    logic                rx_error_bad_frame;
    logic                rx_error_bad_fcs;
    logic [stat_w-1:0]   stat_tx_frames;
    logic [stat_w-1:0]   stat_tx_underflow;
    logic [stat_w-1:0]   stat_rx_good;
    logic [stat_w-1:0]   stat_rx_bad_frame;
    logic [stat_w-1:0]   stat_rx_bad_fcs;
    logic [stat_w-1:0]   stat_rx_frames;
    logic [7:0]          cfg_ifg;
    logic                cfg_tx_enable;
    logic                cfg_rx_enable;

    integer seed = 32'h0fb08ba7;
    int cycle_count = 0;

    // transmit capture state.
    logic [3:0] tx_nibbles [$];
    logic       tx_en_q = 1'b0;
    int         tx_frames_seen = 0;
    int         tx_er_nibbles = 0;
    int         tx_gap = 0;
    int         gap_run = 0;
    int         tx_start_pulses = 0;
    int         underflow_pulses = 0;

    // receive capture state.
    logic [7:0] rx_bytes [$];
    logic       rx_last_user = 1'b0;
    int         rx_last_count = 0;
    int         rx_last_index = 0;
    int         rx_start_pulses = 0;
    int         rx_good_pulses = 0;
    int         rx_bad_frame_pulses = 0;
    int         rx_bad_fcs_pulses = 0;

    eth_mac_mii dut (.*);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            stop_with_error($sformatf("timeout: run exceeded %0d clock cycles", timeout_cycles));
        end
    end

    // nibbles are recorded while mii_tx_en is high, the gap is the low run before a frame.
    always @(negedge clk) begin
        if (mii_tx_en) begin
            if (!tx_en_q) begin
                tx_gap = gap_run;
            end
            tx_nibbles.push_back(mii_txd);
            if (mii_tx_er) begin
                tx_er_nibbles++;
            end
        end else begin
            if (tx_en_q) begin
                tx_frames_seen++;
            end
            gap_run = tx_en_q ? 1 : gap_run + 1;
        end
        if (tx_start_packet) begin
            tx_start_pulses++;
        end
        if (tx_error_underflow) begin
            underflow_pulses++;
        end
        tx_en_q = mii_tx_en;
    end

    always @(negedge clk) begin
        if (rx_tvalid) begin
            rx_bytes.push_back(rx_tdata);
            if (rx_tlast) begin
                rx_last_count++;
                rx_last_index = rx_bytes.size() - 1;
                rx_last_user = rx_tuser;
            end
        end
        if (rx_start_packet) begin
            rx_start_pulses++;
        end
        if (rx_frame_good) begin
            rx_good_pulses++;
        end
        if (rx_error_bad_frame) begin
            rx_bad_frame_pulses++;
        end
        if (rx_error_bad_fcs) begin
            rx_bad_fcs_pulses++;
        end
    end

    `include "eth_mac_mii_tb_tasks.svh"

    initial begin
        reset = 1'b1;
        tx_tdata = 8'h00;
        tx_tvalid = 1'b0;
        tx_tlast = 1'b0;
        mii_rxd = 4'h0;
        mii_rx_dv = 1'b0;
        mii_rx_er = 1'b0;
        cfg_ifg = 8'd12;
        cfg_tx_enable = 1'b1;
        cfg_rx_enable = 1'b1;
        repeat (5) @(negedge clk);
        reset = 1'b0;

        check_reset_state();
        test_padded_tx();
        test_back_to_back_tx();
        test_good_rx();
        test_bad_rx();
        test_tx_underflow();
        test_loopback();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verification
hdl/eth_mii_pkg.sv
hdl/eth_mac_mii_tx.sv
hdl/eth_mac_mii_rx.sv
hdl/eth_mac_stats.sv
hdl/eth_mac_mii.sv
verification/eth_mac_mii_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the MII MAC testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -Wno-fatal --top-module eth_mac_mii_tb \
    -f flist.f --Mdir "$build_dir" -o eth_mac_mii_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/eth_mac_mii_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test completed successfully" "$log_file"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $log_file"
    exit 1
fi
